// ==== engine_cu_setup.f ====
engine_cu_setup_pkg.sv
setup_fsm.sv
stride_counter.sv
request_offset_gen.sv
request_fifo.sv
engine_cu_setup.sv
engine_cu_setup_sva.sv
engine_cu_setup_tb.sv

// ==== engine_cu_setup.sv ====
// Serial read engine top level, instances and wires only.
// counter_width must stay 32 to match the request payload.
// prog_thresh must be at most fifo_depth - 4.

`timescale 1ns/1ns

module engine_cu_setup #(
    parameter int counter_width = 32,
    parameter int fifo_depth    = 16,
    parameter int prog_thresh   = 8
) (
    input  logic                                               ap_clk,
    input  logic                                               areset_engine,
    input  logic                                               start_in,
    input  logic                                               config_valid,
    input  logic [counter_width-1:0]                           start_read,
    input  logic [counter_width-1:0]                           end_read,
    input  logic [counter_width-1:0]                           stride,
    input  logic [engine_cu_setup_pkg::shift_amount_width-1:0] shift_amount,
    input  logic                                               shift_direction,
    input  logic                                               flush_mode,
    input  logic [engine_cu_setup_pkg::id_buffer_width-1:0]    id_buffer,
    input  logic                                               request_rd_en,
    output logic                                               ready_out,
    output logic                                               done_out,
    output logic                                               request_valid,
    output logic [counter_width-1:0]                           request_offset,
    output logic [counter_width-1:0]                           request_data,
    output logic [engine_cu_setup_pkg::id_buffer_width-1:0]    request_id_buffer
);

    import engine_cu_setup_pkg::*;

    // ----------------------------------------------------------------------
    // Internal wires
    // ----------------------------------------------------------------------
    logic                          counter_load;
    logic                          counter_enable;
    logic [counter_width-1:0]      counter_load_value;
    logic [counter_width-1:0]      counter_stride;
    logic [counter_width-1:0]      count;
    logic                          push;
    logic [shift_amount_width-1:0] cfg_shift_amount;
    logic                          cfg_shift_direction;
    logic                          cfg_flush_mode;
    logic [id_buffer_width-1:0]    cfg_id_buffer;
    logic                          fifo_wr_en;
    request_payload_t              fifo_din;
    request_payload_t              fifo_dout;
    logic                          fifo_empty;
    logic                          fifo_prog_full;

    setup_fsm #(
        .counter_width(counter_width)
    ) i_setup_fsm (
        .ap_clk             (ap_clk),
        .areset_engine      (areset_engine),
        .start_in           (start_in),
        .config_valid       (config_valid),
        .start_read         (start_read),
        .end_read           (end_read),
        .stride             (stride),
        .shift_amount       (shift_amount),
        .shift_direction    (shift_direction),
        .flush_mode         (flush_mode),
        .id_buffer          (id_buffer),
        .count              (count),
        .fifo_empty         (fifo_empty),
        .fifo_prog_full     (fifo_prog_full),
        .counter_load       (counter_load),
        .counter_enable     (counter_enable),
        .counter_load_value (counter_load_value),
        .counter_stride     (counter_stride),
        .push               (push),
        .cfg_shift_amount   (cfg_shift_amount),
        .cfg_shift_direction(cfg_shift_direction),
        .cfg_flush_mode     (cfg_flush_mode),
        .cfg_id_buffer      (cfg_id_buffer),
        .ready_out          (ready_out),
        .done_out           (done_out)
    );

    stride_counter #(
        .counter_width(counter_width)
    ) i_stride_counter (
        .ap_clk       (ap_clk),
        .areset_engine(areset_engine),
        .enable       (counter_enable),
        .load         (counter_load),
        .load_value   (counter_load_value),
        .stride       (counter_stride),
        .count        (count)
    );

    request_offset_gen #(
        .counter_width(counter_width)
    ) i_request_offset_gen (
        .ap_clk         (ap_clk),
        .count          (count),
        .push_in        (push),
        .shift_amount   (cfg_shift_amount),
        .shift_direction(cfg_shift_direction),
        .flush_mode     (cfg_flush_mode),
        .id_buffer      (cfg_id_buffer),
        .wr_en          (fifo_wr_en),
        .wr_payload     (fifo_din)
    );

    request_fifo #(
        .data_width ($bits(request_payload_t)),
        .depth      (fifo_depth),
        .prog_thresh(prog_thresh)
    ) i_request_fifo (
        .ap_clk       (ap_clk),
        .areset_engine(areset_engine),
        .wr_en        (fifo_wr_en),
        .din          (fifo_din),
        .rd_en        (request_rd_en),
        .dout         (fifo_dout),
        .valid        (request_valid),
        .empty        (fifo_empty),
        .full         (),
        .prog_full    (fifo_prog_full)
    );

    // Unpack the popped request
    assign request_offset    = fifo_dout.offset;
    assign request_data      = fifo_dout.data;
    assign request_id_buffer = fifo_dout.id_buffer;

endmodule : engine_cu_setup

// ==== engine_cu_setup_pkg.sv ====
// Shared types and constants for the serial read engine.
// The request payload fixes the counter width at 32 bits.

package engine_cu_setup_pkg;

    // ----------------------------------------------------------------------
    // Cache geometry used by the flush interleave
    // ----------------------------------------------------------------------
    localparam int cache_num_ways      = 4;
    localparam int cache_line_size_log = 6;
    localparam int cache_way_bits      = $clog2(cache_num_ways);

    // ----------------------------------------------------------------------
    // Field widths
    // ----------------------------------------------------------------------
    localparam int payload_counter_width = 32;
    localparam int id_buffer_width       = 8;
    localparam int shift_amount_width    = 5;

    // Engine states
    typedef enum logic [3:0] {
        st_reset,
        st_idle,
        st_setup,
        st_start,
        st_busy,
        st_busy_trans,
        st_pause_trans,
        st_pause,
        st_done
    } setup_state_t;

    // One memory read request, 72 bits
    typedef struct packed {
        logic [payload_counter_width-1:0] offset;
        logic [payload_counter_width-1:0] data;
        logic [id_buffer_width-1:0]       id_buffer;
    } request_payload_t;

endpackage : engine_cu_setup_pkg

// ==== engine_cu_setup_sva.sv ====
// Protocol rules of the read engine, bound into engine_cu_setup.
// Checks run on ap_clk and most are held off while reset is high.

`timescale 1ns/1ns

module engine_cu_setup_sva (
    input logic ap_clk,
    input logic areset_engine,
    input logic start_in,
    input logic request_rd_en,
    input logic request_valid,
    input logic ready_out,
    input logic done_out
);

    int fail_count = 0;

    // ----------------------------------------------------------------------
    // Read side
    // ----------------------------------------------------------------------
    assert property (@(posedge ap_clk) disable iff (areset_engine)
        request_valid |-> $past(request_rd_en))
    else begin
        fail_count++;
        $error("request_valid high without a pop in the previous cycle");
    end

    // Engine cannot report ready while a popped entry is still on the outputs
    assert property (@(posedge ap_clk) disable iff (areset_engine)
        request_valid |-> !ready_out)
    else begin
        fail_count++;
        $error("ready_out high while request_valid is pending");
    end

    // ----------------------------------------------------------------------
    // Status outputs
    // ----------------------------------------------------------------------
    assert property (@(posedge ap_clk)
        $fell(areset_engine) |-> (!ready_out && !done_out))
    else begin
        fail_count++;
        $error("ready_out or done_out high right after reset");
    end

    // Only a start request may pull done_out down
    assert property (@(posedge ap_clk) disable iff (areset_engine)
        !$past(start_in) |-> !$fell(done_out))
    else begin
        fail_count++;
        $error("done_out fell while start_in was low");
    end

endmodule : engine_cu_setup_sva

// ==== engine_cu_setup_tb.sv ====
// Testbench for the serial read engine, default parameters (depth 16, threshold 8).
// Pops are random from a fixed seed. One run holds pops off to force back-pressure.

`timescale 1ns/1ns

module engine_cu_setup_tb;

    import engine_cu_setup_pkg::*;

    // Requests of the five runs below, used for the timeout
    localparam int total_requests = 10 + 0 + 8 + 23 + 60;
    localparam int cycle_limit    = 20 * total_requests + 2000;

    logic                          ap_clk;
    logic                          areset_engine;
    logic                          start_in;
    logic                          config_valid;
    logic [31:0]                   start_read;
    logic [31:0]                   end_read;
    logic [31:0]                   stride;
    logic [shift_amount_width-1:0] shift_amount;
    logic                          shift_direction;
    logic                          flush_mode;
    logic [id_buffer_width-1:0]    id_buffer;
    logic                          request_rd_en;
    logic                          ready_out;
    logic                          done_out;
    logic                          request_valid;
    logic [31:0]                   request_offset;
    logic [31:0]                   request_data;
    logic [id_buffer_width-1:0]    request_id_buffer;

    int   seed = 74322;
    int   errors = 0;
    int   checked = 0;
    int   cycles = 0;
    logic pop_enable = 1'b0;

    // Expected requests, oldest first
    logic [31:0]                exp_data[$];
    logic [31:0]                exp_offset[$];
    logic [id_buffer_width-1:0] exp_id[$];

    engine_cu_setup i_engine_cu_setup (.*);

    bind engine_cu_setup engine_cu_setup_sva i_engine_cu_setup_sva (
        .ap_clk       (ap_clk),
        .areset_engine(areset_engine),
        .start_in     (start_in),
        .request_rd_en(request_rd_en),
        .request_valid(request_valid),
        .ready_out    (ready_out),
        .done_out     (done_out)
    );

    initial begin
        ap_clk = 1'b0;
        forever #2 ap_clk = ~ap_clk;
    end

    // Byte offset of a count: cache-line interleave in flush mode, else a shift
    function automatic logic [31:0] expected_offset(input logic [31:0] c,
                                                    input logic [shift_amount_width-1:0] sa,
                                                    input logic dir, input logic flush);
        if (flush) begin
            return (c / cache_num_ways) * (cache_num_ways * (1 << cache_line_size_log))
                 + (c % cache_num_ways) * (1 << cache_line_size_log);
        end else if (dir) begin
            return c << sa;
        end
        return c >> sa;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, want);
        errors++;
    endtask

    // ----------------------------------------------------------------------
    // One run: load the reference list, start, disturb inputs, wait for done
    // ----------------------------------------------------------------------
    task automatic run_engine(input logic [31:0] first, input logic [31:0] last,
                              input logic [31:0] step, input logic [shift_amount_width-1:0] sa,
                              input logic dir, input logic flush,
                              input logic [id_buffer_width-1:0] tag, input bit hold_pops);
        logic [31:0] c;
        c = first;
        while (c < last) begin
            exp_data.push_back(c);
            exp_offset.push_back(expected_offset(c, sa, dir, flush));
            exp_id.push_back(tag);
            c = c + step;
        end
        @(posedge ap_clk);
        start_read      <= first;
        end_read        <= last;
        stride          <= step;
        shift_amount    <= sa;
        shift_direction <= dir;
        flush_mode      <= flush;
        id_buffer       <= tag;
        start_in        <= 1'b1;
        config_valid    <= 1'b1;
        pop_enable      <= !hold_pops;
        do @(negedge ap_clk); while (ready_out);
        // Configuration is latched, so these must have no effect
        @(posedge ap_clk);
        start_read      <= $random(seed);
        end_read        <= $random(seed);
        stride          <= $random(seed);
        shift_amount    <= shift_amount_width'($random(seed));
        shift_direction <= 1'($random(seed));
        flush_mode      <= 1'($random(seed));
        id_buffer       <= id_buffer_width'($random(seed));
        if (hold_pops) begin
            // Early withdraw, so the engine idles while the FIFO still holds requests
            start_in <= 1'b0;
            repeat (300) @(posedge ap_clk);
            pop_enable <= 1'b1;
        end
        do @(negedge ap_clk); while (!done_out);
        assert (exp_data.size() == 0) else begin
            report_mismatch("outstanding requests at done", exp_data.size(), 0);
        end
        @(posedge ap_clk);
        start_in     <= 1'b0;
        config_valid <= 1'b0;
        do @(negedge ap_clk); while (!ready_out);
    endtask

    // Random pops while enabled
    always @(posedge ap_clk) begin
        if (areset_engine || !pop_enable) begin
            request_rd_en <= 1'b0;
        end else begin
            request_rd_en <= 1'($random(seed));
        end
    end

    // Scoreboard, sampled away from the active edge
    always @(negedge ap_clk) begin
        if (!areset_engine && request_valid) begin
            if (exp_data.size() == 0) begin
                $display("Unexpected request popped at %0t with data %0d", $time, request_data);
                errors++;
            end else begin
                assert (request_data == exp_data[0]) else begin
                    report_mismatch("request_data", request_data, exp_data[0]);
                end
                assert (request_offset == exp_offset[0]) else begin
                    report_mismatch("request_offset", request_offset, exp_offset[0]);
                end
                assert (request_id_buffer == exp_id[0]) else begin
                    report_mismatch("request_id_buffer", 32'(request_id_buffer), 32'(exp_id[0]));
                end
                void'(exp_data.pop_front());
                void'(exp_offset.pop_front());
                void'(exp_id.pop_front());
                checked++;
            end
        end
    end

    always @(posedge ap_clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the engine did not finish", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        areset_engine   = 1'b1;
        start_in        = 1'b0;
        config_valid    = 1'b0;
        start_read      = '0;
        end_read        = '0;
        stride          = '0;
        shift_amount    = '0;
        shift_direction = 1'b0;
        flush_mode      = 1'b0;
        id_buffer       = '0;
        request_rd_en   = 1'b0;
        repeat (4) @(posedge ap_clk);
        areset_engine <= 1'b0;
        do @(negedge ap_clk); while (!ready_out);

        run_engine(32'd3, 32'd40, 32'd4, 5'd2, 1'b1, 1'b0, 8'h5a, 1'b0);
        run_engine(32'd5, 32'd5, 32'd1, 5'd0, 1'b1, 1'b0, 8'h11, 1'b0);
        run_engine(32'd100, 32'd164, 32'd8, 5'd3, 1'b0, 1'b0, 8'hc3, 1'b0);
        run_engine(32'd0, 32'd23, 32'd1, 5'd0, 1'b0, 1'b1, 8'h7e, 1'b0);
        run_engine(32'd10, 32'd70, 32'd1, 5'd1, 1'b1, 1'b0, 8'h2d, 1'b1);

        $display("Errors: %0d checks, %0d assertions, %0d requests checked", errors,
                 i_engine_cu_setup.i_engine_cu_setup_sva.fail_count, checked);
        if (errors == 0 && i_engine_cu_setup.i_engine_cu_setup_sva.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : engine_cu_setup_tb

// ==== request_fifo.sv ====
// Synchronous FIFO with registered read and a one cycle valid.
// Writes when full and reads when empty are dropped.

`timescale 1ns/1ns

module request_fifo #(
    parameter int data_width  = 72,
    parameter int depth       = 16,
    parameter int prog_thresh = 8
) (
    input  logic                  ap_clk,
    input  logic                  areset_engine,
    input  logic                  wr_en,
    input  logic [data_width-1:0] din,
    input  logic                  rd_en,
    output logic [data_width-1:0] dout,
    output logic                  valid,
    output logic                  empty,
    output logic                  full,
    output logic                  prog_full
);

    localparam int addr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_width  = $clog2(depth + 1);
    localparam logic [addr_width-1:0] last_addr = addr_width'(depth - 1);

    logic [data_width-1:0] mem [depth];
    logic [addr_width-1:0] wr_ptr;
    logic [addr_width-1:0] rd_ptr;
    logic [cnt_width-1:0]  occupancy;
    logic                  do_write;
    logic                  do_read;

    assign do_write  = wr_en & ~full;
    assign do_read   = rd_en & ~empty;
    assign empty     = (occupancy == '0);
    assign full      = (occupancy == cnt_width'(depth));
    assign prog_full = (occupancy >= cnt_width'(prog_thresh));

    // ----------------------------------------------------------------------
    // Pointers and occupancy
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
            valid     <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == last_addr) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == last_addr) ? '0 : rd_ptr + 1'b1;
            end
            occupancy <= occupancy + cnt_width'(do_write) - cnt_width'(do_read);
            valid     <= do_read;
        end
    end

    // Storage and read data
    always_ff @(posedge ap_clk) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
        if (do_read) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule : request_fifo

// ==== request_offset_gen.sv ====
// Builds the request for a count and registers it with the push.
// Flush mode interleaves consecutive counts across cache lines.

`timescale 1ns/1ns

module request_offset_gen #(
    parameter int counter_width = 32
) (
    input  logic                                               ap_clk,
    input  logic [counter_width-1:0]                           count,
    input  logic                                               push_in,
    input  logic [engine_cu_setup_pkg::shift_amount_width-1:0] shift_amount,
    input  logic                                               shift_direction,
    input  logic                                               flush_mode,
    input  logic [engine_cu_setup_pkg::id_buffer_width-1:0]    id_buffer,
    output logic                                               wr_en,
    output engine_cu_setup_pkg::request_payload_t              wr_payload
);

    import engine_cu_setup_pkg::*;

    logic [counter_width-1:0] offset;
    logic [counter_width-1:0] group_base;
    logic [counter_width-1:0] line_base;

    // Group of ways, then the line inside the group
    assign group_base = (count >> cache_way_bits) << (cache_line_size_log + cache_way_bits);
    assign line_base  = (count & counter_width'(cache_num_ways - 1)) << cache_line_size_log;

    always_comb begin
        if (flush_mode) begin
            offset = group_base | line_base;
        end else if (shift_direction) begin
            offset = count << shift_amount;
        end else begin
            offset = count >> shift_amount;
        end
    end

    always_ff @(posedge ap_clk) begin
        wr_en                <= push_in;
        wr_payload.offset    <= offset;
        wr_payload.data      <= count;
        wr_payload.id_buffer <= id_buffer;
    end

endmodule : request_offset_gen

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the read engine testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module engine_cu_setup_tb -f engine_cu_setup.f -o engine_cu_setup_sim; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/engine_cu_setup_sim +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

// ==== setup_fsm.sv ====
// Control FSM of the read engine. Configuration is latched on start.
// prog_full is sampled one cycle late, so up to a few pushes follow it.

`timescale 1ns/1ns

module setup_fsm #(
    parameter int counter_width = 32
) (
    input  logic                                               ap_clk,
    input  logic                                               areset_engine,
    input  logic                                               start_in,
    input  logic                                               config_valid,
    input  logic [counter_width-1:0]                           start_read,
    input  logic [counter_width-1:0]                           end_read,
    input  logic [counter_width-1:0]                           stride,
    input  logic [engine_cu_setup_pkg::shift_amount_width-1:0] shift_amount,
    input  logic                                               shift_direction,
    input  logic                                               flush_mode,
    input  logic [engine_cu_setup_pkg::id_buffer_width-1:0]    id_buffer,
    input  logic [counter_width-1:0]                           count,
    input  logic                                               fifo_empty,
    input  logic                                               fifo_prog_full,
    output logic                                               counter_load,
    output logic                                               counter_enable,
    output logic [counter_width-1:0]                           counter_load_value,
    output logic [counter_width-1:0]                           counter_stride,
    output logic                                               push,
    output logic [engine_cu_setup_pkg::shift_amount_width-1:0] cfg_shift_amount,
    output logic                                               cfg_shift_direction,
    output logic                                               cfg_flush_mode,
    output logic [engine_cu_setup_pkg::id_buffer_width-1:0]    cfg_id_buffer,
    output logic                                               ready_out,
    output logic                                               done_out
);

    import engine_cu_setup_pkg::*;

    setup_state_t             state;
    setup_state_t             next_state;
    logic [counter_width-1:0] cfg_start_read;
    logic [counter_width-1:0] cfg_end_read;
    logic [counter_width-1:0] cfg_stride;
    logic                     prog_full_q;
    logic                     push_q;
    logic                     start_req;
    logic                     count_done;
    logic                     drained;

    assign start_req  = config_valid & start_in;
    assign count_done = (count >= cfg_end_read);

    // FIFO holds nothing and no write is on its way
    assign drained = fifo_empty & ~push_q;

    // ----------------------------------------------------------------------
    // State register and next state
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            state <= st_reset;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_reset:       next_state = st_idle;
            st_idle: begin
                if (start_req) begin
                    next_state = st_setup;
                end
            end
            st_setup:       next_state = st_start;
            st_start:       next_state = st_busy;
            st_busy: begin
                if (count_done) begin
                    next_state = st_done;
                end else if (prog_full_q) begin
                    next_state = st_pause_trans;
                end
            end
            st_pause_trans: next_state = st_pause;
            st_pause: begin
                if (!prog_full_q) begin
                    next_state = st_busy_trans;
                end
            end
            st_busy_trans:  next_state = st_busy;
            st_done: begin
                // Hold until the start request is withdrawn
                if (!start_req) begin
                    next_state = st_idle;
                end
            end
            default:        next_state = st_reset;
        endcase
    end

    // ----------------------------------------------------------------------
    // Configuration latch, taken on the idle to setup step
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (state == st_idle && start_req) begin
            cfg_start_read      <= start_read;
            cfg_end_read        <= end_read;
            cfg_stride          <= stride;
            cfg_shift_amount    <= shift_amount;
            cfg_shift_direction <= shift_direction;
            cfg_flush_mode      <= flush_mode;
            cfg_id_buffer       <= id_buffer;
        end
    end

    // Counter loads during setup and is valid from start on
    assign counter_load       = (state == st_setup);
    assign counter_load_value = cfg_start_read;
    assign counter_stride     = cfg_stride;

    // One push per count, the counter steps with it
    assign push           = (state == st_busy) && !count_done && !prog_full_q;
    assign counter_enable = push;

    // ----------------------------------------------------------------------
    // Registered status
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            prog_full_q <= 1'b0;
            push_q      <= 1'b0;
            ready_out   <= 1'b0;
            done_out    <= 1'b0;
        end else begin
            prog_full_q <= fifo_prog_full;
            push_q      <= push;
            ready_out   <= (next_state == st_idle) && drained;
            done_out    <= (next_state == st_idle || next_state == st_done) && drained;
        end
    end

endmodule : setup_fsm

// ==== stride_counter.sv ====
// Loadable up counter stepping by a stride. Load wins over enable.
// Wraps silently on overflow.

`timescale 1ns/1ns

module stride_counter #(
    parameter int counter_width = 32
) (
    input  logic                     ap_clk,
    input  logic                     areset_engine,
    input  logic                     enable,
    input  logic                     load,
    input  logic [counter_width-1:0] load_value,
    input  logic [counter_width-1:0] stride,
    output logic [counter_width-1:0] count
);

    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            count <= '0;
        end else if (load) begin
            count <= load_value;
        end else if (enable) begin
            count <= count + stride;
        end
    end

endmodule : stride_counter
